// File: design/board_pkg.sv
`default_nettype none

package board_pkg;

    // board clock and I/O widths.
    localparam int clk_mhz = 100;
    localparam int w_key   = 5;
    localparam int w_sw    = 16;
    localparam int w_led   = 16;
    localparam int w_digit = 8;

    // I2S timing, sck runs at 100 MHz / (2 * 16) = 3.125 MHz.
    localparam int sck_half_cycles  = 16;
    localparam int bits_per_channel = 32;  // sck periods per ws half frame.
    localparam int w_sample         = 24;  // INMP441 word length.

    // each display digit stays lit for 2.5 us.
    localparam int digit_period_cycles = 250;

    typedef logic signed [w_sample-1:0] sample_t;  // two's complement mic sample.

    typedef logic [7:0] segments_t;  // a in bit 7 down to the dot in bit 0.

    typedef logic [w_digit-1:0] digit_sel_t;  // one-hot, active high.

    typedef logic [w_led-1:0] led_t;

    // receiver phase within one I2S frame.
    typedef enum logic [1:0] {
        idle,        // waiting for the first bit tick.
        left_wait,   // left half, bits not captured.
        left_shift,  // left half, shifting data in.
        right_skip   // right half, ignored.
    } i2s_state_t;

endpackage

`default_nettype wire

// File: design/tick_gen.sv
`default_nettype none

module tick_gen #(
    parameter int period_cycles = 16
) (
    input  logic clk,
    input  logic reset,
    output logic tick
);

    // sized for the terminal count, kept at least one bit wide.
    typedef logic [$clog2(period_cycles > 1 ? period_cycles : 2)-1:0] count_t;

    count_t count;

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
            tick  <= 1'b0;
        end else if (count == count_t'(period_cycles - 1)) begin
            count <= '0;  // reload at terminal count.
            tick  <= 1'b1;
        end else begin
            count <= count + 1'b1;
            tick  <= 1'b0;
        end
    end

    if (period_cycles > 1) begin : g_single_pulse
        assert property (@(posedge clk) disable iff (reset) tick |=> !tick)
            else $error("tick_gen: tick high on two cycles in a row");
    end

endmodule

`default_nettype wire

// File: design/i2s_receiver.sv
`default_nettype none

module i2s_receiver (
    input  logic               clk,
    input  logic               reset,
    input  logic               bit_tick,
    input  logic               sd,
    output logic               sck,
    output logic               ws,
    output board_pkg::sample_t sample,
    output logic               sample_valid
);

    typedef logic [$clog2(board_pkg::bits_per_channel)-1:0] bit_cnt_t;

    board_pkg::i2s_state_t          state;
    bit_cnt_t                       bit_cnt;    // sck period within the half frame.
    logic [board_pkg::w_sample-2:0] shift;      // all but the last bit of the word.
    logic                           rise_tick;
    logic                           fall_tick;
    logic                           half_done;

    assign rise_tick = bit_tick && !sck;  // sck about to go high.
    assign fall_tick = bit_tick && sck;   // sck about to go low.
    assign half_done = bit_cnt == bit_cnt_t'(board_pkg::bits_per_channel - 1);

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= board_pkg::idle;
            sck          <= 1'b0;
            ws           <= 1'b0;
            bit_cnt      <= '0;
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= 1'b0;
            if (bit_tick) begin
                sck <= !sck;
            end
            // ws and the period count move on falling sck edges.
            if (fall_tick && state != board_pkg::idle) begin
                if (half_done) begin
                    bit_cnt <= '0;
                    ws      <= (state != board_pkg::right_skip);
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
            case (state)
                board_pkg::idle: begin
                    if (bit_tick) begin
                        state   <= board_pkg::left_wait;
                        bit_cnt <= bit_cnt_t'(board_pkg::bits_per_channel - 1);  // short first half.
                    end
                end
                board_pkg::left_wait: begin
                    if (fall_tick && half_done) begin
                        state <= board_pkg::right_skip;
                    end else if (fall_tick && bit_cnt == '0) begin
                        state <= board_pkg::left_shift;  // one-bit I2S delay is over.
                    end
                end
                board_pkg::left_shift: begin
                    if (rise_tick) begin
                        shift <= {shift[board_pkg::w_sample-3:0], sd};
                        if (bit_cnt == bit_cnt_t'(board_pkg::w_sample)) begin
                            sample       <= {shift, sd};  // lsb arrives on this edge.
                            sample_valid <= 1'b1;
                            state        <= board_pkg::left_wait;
                        end
                    end
                end
                board_pkg::right_skip: begin
                    if (fall_tick && half_done) begin
                        state <= board_pkg::left_wait;
                    end
                end
                default: state <= board_pkg::idle;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (reset) $changed(ws) |-> $fell(sck))
        else $error("i2s_receiver: ws changed away from a falling sck edge");

    assert property (@(posedge clk) disable iff (reset) sample_valid |=> !sample_valid)
        else $error("i2s_receiver: sample_valid longer than one cycle");

    assert property (@(posedge clk) disable iff (reset) sample_valid |-> !ws)
        else $error("i2s_receiver: sample_valid outside the left channel");

endmodule

`default_nettype wire

// File: design/level_meter.sv
`default_nettype none

module level_meter (
    input  logic               clk,
    input  logic               reset,
    input  board_pkg::sample_t sample,
    input  logic               sample_valid,
    input  logic               peak_clear,
    output board_pkg::led_t    led
);

    // bar bit 0 lights once the peak reaches bit 7.
    localparam int led_offset = 7;

    logic [board_pkg::w_sample-1:0] magnitude;
    logic [board_pkg::w_sample-1:0] peak;
    board_pkg::led_t                bar;

    // one's complement keeps the most negative sample in range.
    assign magnitude = sample[board_pkg::w_sample-1] ? ~sample : sample;

    always_comb begin
        for (int i = 0; i < board_pkg::w_led; i++) begin
            bar[i] = (peak >> (i + led_offset)) != '0;  // highest set bit at i+7 or above.
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            peak <= '0;
            led  <= '0;
        end else begin
            if (peak_clear) begin
                peak <= '0;  // clear wins over a new sample.
            end else if (sample_valid && magnitude > peak) begin
                peak <= magnitude;
            end
            led <= bar;
        end
    end

    assert property (@(posedge clk) disable iff (reset) (led & (led + 1'b1)) == '0)
        else $error("level_meter: led %h is not a thermometer", led);

endmodule

`default_nettype wire

// File: design/seven_seg_display.sv
`default_nettype none

module seven_seg_display (
    input  logic                   clk,
    input  logic                   reset,
    input  board_pkg::sample_t     sample,
    input  logic                   sample_valid,
    input  logic                   freeze,
    input  logic                   scan_tick,
    output board_pkg::segments_t   segments,
    output board_pkg::digit_sel_t  digit
);

    board_pkg::sample_t                    shown;
    logic [4*board_pkg::w_digit-1:0]       shown_wide;  // zero nibbles above the sample.
    logic [$clog2(board_pkg::w_digit)-1:0] index;
    logic                                  lit;         // set by the first scan tick.
    logic [3:0]                            nibble;
    board_pkg::segments_t                  pattern;

    assign shown_wide = {{(4 * board_pkg::w_digit - board_pkg::w_sample){1'b0}}, shown};
    assign nibble     = shown_wide[{index, 2'b00} +: 4];

    always_comb begin
        case (nibble)        // abcdefg plus dot.
            4'h0: pattern = 8'b1111_1100;
            4'h1: pattern = 8'b0110_0000;
            4'h2: pattern = 8'b1101_1010;
            4'h3: pattern = 8'b1111_0010;
            4'h4: pattern = 8'b0110_0110;
            4'h5: pattern = 8'b1011_0110;
            4'h6: pattern = 8'b1011_1110;
            4'h7: pattern = 8'b1110_0000;
            4'h8: pattern = 8'b1111_1110;
            4'h9: pattern = 8'b1111_0110;
            4'ha: pattern = 8'b1110_1110;
            4'hb: pattern = 8'b0011_1110;
            4'hc: pattern = 8'b1001_1100;
            4'hd: pattern = 8'b0111_1010;
            4'he: pattern = 8'b1001_1110;
            default: pattern = 8'b1000_1110;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            shown    <= '0;
            index    <= '0;
            lit      <= 1'b0;
            segments <= '0;  // blank.
            digit    <= '0;  // no anode on.
        end else begin
            if (sample_valid && !freeze) begin
                shown <= sample;
            end
            if (scan_tick) begin
                lit <= 1'b1;
                if (lit) begin
                    index <= index + 1'b1;  // wraps from 7 to 0.
                end
            end
            // select and pattern leave the same register stage.
            if (lit) begin
                digit <= board_pkg::digit_sel_t'(1) << index;
            end
            if (lit && int'(index) < board_pkg::w_sample / 4) begin
                segments <= pattern;
            end else begin
                segments <= '0;  // upper digits stay dark.
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset) $onehot0(digit))
        else $error("seven_seg_display: digit select %b not one-hot", digit);

endmodule

`default_nettype wire

// File: design/lab_top.sv
`default_nettype none

module lab_top (
    input  logic                         clk,
    input  logic                         reset,
    input  logic [board_pkg::w_key-1:0]  key,
    input  logic [board_pkg::w_sw-1:0]   sw,
    input  logic                         sd,
    output logic                         sck,
    output logic                         ws,
    output board_pkg::led_t              led,
    output board_pkg::segments_t         segments,
    output board_pkg::digit_sel_t        digit
);

    logic               bit_tick;
    logic               scan_tick;
    board_pkg::sample_t sample;
    logic               sample_valid;

    // INMP441 accepts sck from 0.5 to 3.2 MHz.
    initial begin
        assert (board_pkg::clk_mhz * 1000 / (2 * board_pkg::sck_half_cycles) <= 3200 &&
                board_pkg::clk_mhz * 1000 / (2 * board_pkg::sck_half_cycles) >= 500)
            else $error("lab_top: sck outside the microphone range");
    end

    tick_gen #(.period_cycles(board_pkg::sck_half_cycles)) u_bit_tick (
        .clk   (clk),
        .reset (reset),
        .tick  (bit_tick)
    );

    tick_gen #(.period_cycles(board_pkg::digit_period_cycles)) u_scan_tick (
        .clk   (clk),
        .reset (reset),
        .tick  (scan_tick)
    );

    i2s_receiver u_i2s_receiver (
        .clk          (clk),
        .reset        (reset),
        .bit_tick     (bit_tick),
        .sd           (sd),
        .sck          (sck),
        .ws           (ws),
        .sample       (sample),
        .sample_valid (sample_valid)
    );

    level_meter u_level_meter (
        .clk          (clk),
        .reset        (reset),
        .sample       (sample),
        .sample_valid (sample_valid),
        .peak_clear   (key[1]),  // btnc in the board key order.
        .led          (led)
    );

    seven_seg_display u_seven_seg_display (
        .clk          (clk),
        .reset        (reset),
        .sample       (sample),
        .sample_valid (sample_valid),
        .freeze       (sw[0]),
        .scan_tick    (scan_tick),
        .segments     (segments),
        .digit        (digit)
    );

endmodule

`default_nettype wire

// File: design/board_top.sv
`default_nettype none

module board_top (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          btnc,
    input  logic                          btnu,
    input  logic                          btnl,
    input  logic                          btnr,
    input  logic                          btnd,
    input  logic [board_pkg::w_sw-1:0]    sw,
    output board_pkg::led_t               led,
    output logic                          ca,
    output logic                          cb,
    output logic                          cc,
    output logic                          cd,
    output logic                          ce,
    output logic                          cf,
    output logic                          cg,
    output logic                          dp,
    output logic [board_pkg::w_digit-1:0] an,
    output logic                          jd_lr,
    output logic                          jd_ws,
    output logic                          jd_sck,
    input  logic                          jd_sd,
    output logic                          jd_gnd,
    output logic                          jd_vcc
);

    board_pkg::segments_t  segments;
    board_pkg::digit_sel_t digit;

    assign {ca, cb, cc, cd, ce, cf, cg, dp} = ~segments;  // cathodes are active low.
    assign an = ~digit;

    assign jd_lr  = 1'b0;  // mic answers in the left slot.
    assign jd_gnd = 1'b0;
    assign jd_vcc = 1'b1;

    lab_top u_lab_top (
        .clk      (clk),
        .reset    (reset),
        .key      ({btnd, btnu, btnl, btnc, btnr}),
        .sw       (sw),
        .sd       (jd_sd),
        .sck      (jd_sck),
        .ws       (jd_ws),
        .led      (led),
        .segments (segments),
        .digit    (digit)
    );

endmodule

`default_nettype wire

// File: tests/i2s_mic_model.sv
`default_nettype none

module i2s_mic_model #(
    parameter logic [31:0] seed = 32'h0000_0001
) (
    input  logic        sck,
    input  logic        ws,
    output logic        sd,
    output logic [23:0] ref_word,    // last word shifted out in full.
    output int          word_count
);

    logic [31:0] lfsr;
    logic [23:0] word;
    logic        ws_q;     // ws at the previous rising sck edge.
    int          bit_pos;  // bits already sampled from the current word.

    // right-shifting Galois LFSR, x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return state[0] ? (state >> 1) ^ 32'h8020_0003 : state >> 1;
    endfunction

    initial begin
        lfsr       = seed;
        word       = '0;
        ws_q       = 1'b0;
        bit_pos    = 24;
        sd         = 1'b0;
        ref_word   = '0;
        word_count = 0;
    end

    // ws is stable on rising sck edges, so the left half is found here.
    always @(posedge sck) begin
        if (!ws && ws_q) begin
            for (int i = 0; i < 24; i++) begin
                word = {word[22:0], lfsr[0]};  // one LFSR step per bit.
                lfsr = lfsr_next(lfsr);
            end
            if (word_count == 0) begin
                word[23] = 1'b1;  // start with a negative sample.
            end
            bit_pos = 0;
        end else if (bit_pos < 24) begin
            bit_pos = bit_pos + 1;
            if (bit_pos == 24) begin
                ref_word   <= word;
                word_count <= word_count + 1;
            end
        end
        ws_q = ws;
    end

    // msb first, one sck period after ws falls.
    always @(negedge sck) begin
        sd <= (bit_pos < 24) ? word[23 - bit_pos] : 1'b0;
    end

endmodule

`default_nettype wire

// File: tests/tb_board_top.sv
`default_nettype none

module tb_board_top;

    localparam logic [31:0] seed       = 32'ha0fe_db3a;
    localparam int          n_frames   = 12;
    localparam int          max_cycles = 40000;  // 12 frames of 2048 clocks plus margin.

    logic        clk;
    logic        reset;
    logic        btnc;
    logic        btnu;
    logic        btnl;
    logic        btnr;
    logic        btnd;
    logic [15:0] sw;
    logic [15:0] led;
    logic [7:0]  seg_pins;  // ca down to dp, active low.
    logic [7:0]  an;
    logic        jd_lr;
    logic        jd_ws;
    logic        jd_sck;
    logic        jd_sd;
    logic        jd_gnd;
    logic        jd_vcc;
    logic [23:0] ref_word;
    int          word_count;

    int          errors = 0;
    int          cycles = 0;
    int          since_reset;
    int          half_len;    // clocks since the last sck edge.
    int          ws_len;      // rising sck edges since the last ws edge.
    int          scan_steps;
    int          an_hold;     // clocks since an last changed.
    int          count_q;
    int          cur_digit;
    logic        sck_q;
    logic        ws_q;
    logic        sck_seen;
    logic        ws_seen;
    logic [7:0]  an_q;
    logic [7:0]  scan_mask;   // digits lit in the current scan window.
    logic [23:0] exp_shown;
    logic [23:0] exp_peak;
    logic [15:0] exp_led;
    logic [7:0]  exp_seg;

    board_top u_dut (
        .clk    (clk),
        .reset  (reset),
        .btnc   (btnc),
        .btnu   (btnu),
        .btnl   (btnl),
        .btnr   (btnr),
        .btnd   (btnd),
        .sw     (sw),
        .led    (led),
        .ca     (seg_pins[7]),
        .cb     (seg_pins[6]),
        .cc     (seg_pins[5]),
        .cd     (seg_pins[4]),
        .ce     (seg_pins[3]),
        .cf     (seg_pins[2]),
        .cg     (seg_pins[1]),
        .dp     (seg_pins[0]),
        .an     (an),
        .jd_lr  (jd_lr),
        .jd_ws  (jd_ws),
        .jd_sck (jd_sck),
        .jd_sd  (jd_sd),
        .jd_gnd (jd_gnd),
        .jd_vcc (jd_vcc)
    );

    i2s_mic_model #(.seed(seed)) u_mic (
        .sck        (jd_sck),
        .ws         (jd_ws),
        .sd         (jd_sd),
        .ref_word   (ref_word),
        .word_count (word_count)
    );

    // active-low glyphs, bit 7 is segment a.
    function automatic logic [7:0] hex_glyph(input logic [3:0] value);
        case (value)
            4'h0: return 8'b0000_0011;
            4'h1: return 8'b1001_1111;
            4'h2: return 8'b0010_0101;
            4'h3: return 8'b0000_1101;
            4'h4: return 8'b1001_1001;
            4'h5: return 8'b0100_1001;
            4'h6: return 8'b0100_0001;
            4'h7: return 8'b0001_1111;
            4'h8: return 8'b0000_0001;
            4'h9: return 8'b0000_1001;
            4'ha: return 8'b0001_0001;
            4'hb: return 8'b1100_0001;
            4'hc: return 8'b0110_0011;
            4'hd: return 8'b1000_0101;
            4'he: return 8'b0110_0001;
            default: return 8'b0111_0001;
        endcase
    endfunction

    function automatic int low_digit(input logic [7:0] sel);
        int idx;
        idx = 0;
        for (int i = 0; i < 8; i++) begin
            if (!sel[i]) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    function automatic logic [23:0] magnitude(input logic [23:0] word);
        return word[23] ? ~word : word;  // inverted, not negated.
    endfunction

    function automatic logic [15:0] thermometer(input logic [23:0] level);
        logic [15:0] bar;
        bar = '0;
        for (int i = 0; i < 16; i++) begin
            if (level >= (24'd1 << (i + 7))) begin
                bar[i] = 1'b1;
            end
        end
        return bar;
    endfunction

    always #10 clk = ~clk;

    always_comb begin
        cur_digit = low_digit(an);
        exp_led   = thermometer(exp_peak);
        if (cur_digit < 6) begin
            exp_seg = hex_glyph(exp_shown[4 * cur_digit +: 4]);
        end else begin
            exp_seg = 8'hff;  // digits 6 and 7 stay dark.
        end
    end

    // reference state, read on the same edges that the DUT uses.
    always @(posedge clk) begin
        if (reset) begin
            since_reset <= 0;
            half_len    <= 0;
            ws_len      <= 0;
            scan_steps  <= 0;
            an_hold     <= 0;
            count_q     <= 0;
            sck_q       <= 1'b0;
            ws_q        <= 1'b0;
            sck_seen    <= 1'b0;
            ws_seen     <= 1'b0;
            an_q        <= 8'hff;
            scan_mask   <= '0;
            exp_shown   <= '0;
            exp_peak    <= '0;
        end else begin
            since_reset <= since_reset + 1;
            sck_q       <= jd_sck;
            ws_q        <= jd_ws;
            an_q        <= an;
            half_len    <= (jd_sck != sck_q) ? 1 : half_len + 1;
            an_hold     <= (an != an_q) ? 1 : an_hold + 1;
            if (jd_sck != sck_q) begin
                sck_seen <= 1'b1;
            end
            if (jd_ws != ws_q) begin
                ws_seen <= 1'b1;
                ws_len  <= 0;
            end else if (jd_sck && !sck_q) begin
                ws_len <= ws_len + 1;
            end
            if (an != an_q) begin
                scan_steps <= (scan_steps == 8) ? 1 : scan_steps + 1;
                scan_mask  <= (scan_steps == 8) ? ~an : scan_mask | ~an;
            end
            if (word_count != count_q) begin
                count_q <= word_count;
                if (!sw[0]) begin
                    exp_shown <= ref_word;
                end
                if (magnitude(ref_word) > exp_peak) begin
                    exp_peak <= magnitude(ref_word);
                end
            end
            if (btnc) begin
                exp_peak <= '0;  // next word starts a new peak.
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        since_reset < 16 |-> !jd_sck && !jd_ws)
    else begin
        errors = errors + 1;
        $display("FAILED jd_sck/jd_ws expected 0/0 got %h/%h",
                 $sampled(jd_sck), $sampled(jd_ws));
    end

    assert property (@(posedge clk) disable iff (reset)
        since_reset < 240 |-> an == 8'hff && led == '0 && seg_pins == 8'hff)
    else begin
        errors = errors + 1;
        $display("FAILED an/led/segments expected ff/0000/ff got %h/%h/%h",
                 $sampled(an), $sampled(led), $sampled(seg_pins));
    end

    assert property (@(posedge clk) disable iff (reset) !jd_lr && !jd_gnd && jd_vcc)
    else begin
        errors = errors + 1;
        $display("FAILED jd_lr/jd_gnd/jd_vcc expected 0/0/1 got %h/%h/%h",
                 $sampled(jd_lr), $sampled(jd_gnd), $sampled(jd_vcc));
    end

    assert property (@(posedge clk) disable iff (reset) jd_ws != ws_q |-> !jd_sck)
    else begin
        errors = errors + 1;
        $display("jd_ws changed while jd_sck was high");
    end

    assert property (@(posedge clk) disable iff (reset)
        sck_seen && jd_sck != sck_q |-> half_len == 16)
    else begin
        errors = errors + 1;
        $display("FAILED sck half period expected %h got %h", 16, $sampled(half_len));
    end

    assert property (@(posedge clk) disable iff (reset)
        ws_seen && jd_ws != ws_q |-> ws_len == 32)
    else begin
        errors = errors + 1;
        $display("FAILED ws level length expected %h got %h", 32, $sampled(ws_len));
    end

    assert property (@(posedge clk) disable iff (reset)
        jd_ws && word_count > 0 |-> $onehot(~an))
    else begin
        errors = errors + 1;
        $display("FAILED an expected one low bit got %h", $sampled(an));
    end

    assert property (@(posedge clk) disable iff (reset)
        jd_ws && word_count > 0 |-> seg_pins == exp_seg)
    else begin
        errors = errors + 1;
        $display("FAILED segments expected %h got %h", $sampled(exp_seg), $sampled(seg_pins));
    end

    assert property (@(posedge clk) disable iff (reset)
        jd_ws && word_count > 0 |-> led == exp_led)
    else begin
        errors = errors + 1;
        $display("FAILED led expected %h got %h", $sampled(exp_led), $sampled(led));
    end

    assert property (@(posedge clk) disable iff (reset)
        an != an_q && scan_steps == 8 |-> scan_mask == 8'hff)
    else begin
        errors = errors + 1;
        $display("FAILED scanned digits expected ff got %h", $sampled(scan_mask));
    end

    assert property (@(posedge clk) disable iff (reset) scan_steps > 0 |-> an_hold <= 250)
    else begin
        errors = errors + 1;
        $display("an stayed on one digit for longer than a scan period");
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == max_cycles) begin
            $display("timeout after %0d cycles with %0d of %0d frames received",
                     cycles, word_count, n_frames);
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic wait_words(input int n);
        while (word_count < n) begin
            @(posedge clk);
        end
    endtask

    task automatic wait_ws_high();
        do begin
            @(posedge clk);
        end while (!jd_ws);
        #2;
    endtask

    initial begin
        clk   = 1'b0;
        reset = 1'b1;
        btnc  = 1'b0;
        btnu  = 1'b0;
        btnl  = 1'b0;
        btnr  = 1'b0;
        btnd  = 1'b0;
        sw    = '0;
        repeat (4) @(posedge clk);
        #2;
        reset = 1'b0;
        wait_words(3);
        wait_ws_high();
        sw[0] = 1'b1;  // hold the third word on the display.
        wait_words(5);
        wait_ws_high();
        sw[0] = 1'b0;
        wait_words(7);
        repeat (4) @(posedge clk);
        #2;
        btnc = 1'b1;   // clear between capture and the right half.
        @(posedge clk);
        #2;
        btnc = 1'b0;
        wait_words(n_frames);
        wait_ws_high();
        repeat (100) @(posedge clk);
        $display("%0d errors in %0d frames", errors, word_count);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
design/board_pkg.sv
design/tick_gen.sv
design/i2s_receiver.sv
design/level_meter.sv
design/seven_seg_display.sv
design/lab_top.sv
design/board_top.sv
tests/i2s_mic_model.sv
tests/tb_board_top.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
    verilator --binary --timing --assert -Wno-fatal --top-module tb_board_top -f files.f &&
    ./obj_dir/Vtb_board_top | tee /dev/stderr | grep -q "Testbench passed" ||
    exit 1
